//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := alu_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/alu_datapath.sv
/* combinational operand selection and arithmetic/logic result
   the overflow qualifier and sign condition go on to the writeback stage */

`timescale 1ns/1ps

module alu_datapath
    import alu_pkg::*;
(
    input  alu_req_t              req,
    input  logic [data_width-1:0] imm,
    output dp_result_t            dp
);

    localparam int msb = data_width - 1;

    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width:0]   a_ext;
    logic [data_width:0]   b_ext;
    logic [data_width:0]   cin;
    logic [data_width:0]   value;
    logic                  ov_op;
    logic                  b_sign_eff;

    // A is always rd, B is immediate or rs
    assign a     = req.rd;
    assign b     = req.imm_sel ? imm : req.rs;
    assign a_ext = {1'b0, a};
    assign b_ext = {1'b0, b};
    assign cin   = {{data_width{1'b0}}, req.flags_in.c};

    always_comb begin
        value      = '0;
        ov_op      = 1'b0;
        b_sign_eff = b[msb];
        case (req.op)
            add: begin
                value = a_ext + b_ext;
                ov_op = 1'b1;
            end
            adc: begin
                value = a_ext + b_ext + cin;
                ov_op = 1'b1;
            end
            // cmp is a subtract without writeback
            sub, cmp: begin
                value      = a_ext - b_ext;
                ov_op      = 1'b1;
                b_sign_eff = ~b[msb];
            end
            sbb: begin
                value      = a_ext - b_ext - cin;
                ov_op      = 1'b1;
                b_sign_eff = ~b[msb];
            end
            mov:         value = b_ext;
            and_op, test: value = a_ext & b_ext;
            or_op:       value = a_ext | b_ext;
            xor_op:      value = a_ext ^ b_ext;
            not_op:      value = {1'b0, ~a};
            neg:         value = {1'b0, -a};
            // branch target
            jmp:         value = req.imm_sel ? {1'b0, imm} : a_ext;
            // set gets its bit from cond_eval in writeback
            set:         value = '0;
            default:     value = '0;
        endcase
    end

    assign dp.value   = value;
    assign dp.ov_op   = ov_op;
    // same operand signs but result sign flipped
    assign dp.ov_sign = (a[msb] == b_sign_eff) && (value[msb] != a[msb]);

endmodule

//--- hw/alu_pkg.sv
/* shared width, opcode and condition encodings and the packed structs
   of the execute-stage ALU, imported by each RTL unit */

package alu_pkg;

    // operand and result width
    localparam int data_width = 16;

    // opcodes, counted from zero
    typedef enum logic [7:0] {
        add    = 8'd0,
        sub    = 8'd1,
        adc    = 8'd2,
        sbb    = 8'd3,
        cmp    = 8'd4,
        mov    = 8'd5,
        and_op = 8'd6,
        or_op  = 8'd7,
        xor_op = 8'd8,
        not_op = 8'd9,
        neg    = 8'd10,
        test   = 8'd11,
        jmp    = 8'd12,
        set    = 8'd13
    } alu_op_e;

    // condition codes for jmp and set
    typedef enum logic [3:0] {
        cond_always = 4'd0,
        cond_never  = 4'd1,
        cond_eq     = 4'd2,
        cond_ne     = 4'd3,
        cond_cs     = 4'd4,
        cond_cc     = 4'd5,
        cond_os     = 4'd6,
        cond_oc     = 4'd7,
        cond_p      = 4'd8,
        cond_n      = 4'd9,
        cond_hi     = 4'd10,
        cond_ls     = 4'd11,
        cond_ge     = 4'd12,
        cond_l      = 4'd13,
        cond_g      = 4'd14,
        cond_le     = 4'd15
    } cond_e;

    // overflow, sign, carry, zero
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

    // one operation as issued to the execute stage
    typedef struct packed {
        alu_op_e               op;
        logic [data_width-1:0] rd;
        logic [data_width-1:0] rs;
        logic                  imm_sel;
        cond_e                 cond;
        flags_t                flags_in;
    } alu_req_t;

    // datapath output, bit 16 of value is carry or borrow
    typedef struct packed {
        logic [data_width:0] value;
        logic                ov_op;
        logic                ov_sign;
    } dp_result_t;

endpackage

//--- hw/alu_top.sv
/* execute-stage ALU top, one operation per enabled edge, one cycle latency
   request goes to datapath and condition unit in parallel, then writeback */

`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  alu_req_t              req,
    input  logic [data_width-1:0] imm,
    output logic [data_width-1:0] result,
    output flags_t                flags_out,
    output logic                  write,
    output logic                  should_branch
);

    dp_result_t dp;
    logic       taken;

    alu_datapath datapath_i (
        .req (req),
        .imm (imm),
        .dp  (dp)
    );

    cond_eval cond_eval_i (
        .cond     (req.cond),
        .flags_in (req.flags_in),
        .taken    (taken)
    );

    alu_writeback writeback_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .op            (req.op),
        .dp            (dp),
        .taken         (taken),
        .result        (result),
        .flags_out     (flags_out),
        .write         (write),
        .should_branch (should_branch)
    );

endmodule

//--- hw/alu_writeback.sv
/* register stage of the ALU, merges datapath value and condition result
   and registers result, flags, write strobe and branch level on enable */

`timescale 1ns/1ps

module alu_writeback
    import alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  alu_op_e               op,
    input  dp_result_t            dp,
    input  logic                  taken,
    output logic [data_width-1:0] result,
    output flags_t                flags_out,
    output logic                  write,
    output logic                  should_branch
);

    logic [data_width:0] value_sel;
    flags_t              flags_next;
    logic                write_next;
    logic                branch_next;

    // set returns the condition bit, everything else the datapath value
    assign value_sel = (op == set) ? {{data_width{1'b0}}, taken} : dp.value;

    // v only counts for the arithmetic opcodes
    assign flags_next.v = dp.ov_op & dp.ov_sign;
    assign flags_next.n = value_sel[data_width-1];
    assign flags_next.c = value_sel[data_width];
    assign flags_next.z = (value_sel[data_width-1:0] == '0);

    always_comb begin
        case (op)
            cmp, test, jmp: write_next = 1'b0;
            default:        write_next = 1'b1;
        endcase
    end

    assign branch_next = (op == jmp) ? taken : 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            result        <= '0;
            flags_out     <= '0;
            write         <= 1'b0;
            should_branch <= 1'b0;
        end else if (en) begin
            result        <= value_sel[data_width-1:0];
            flags_out     <= flags_next;
            write         <= write_next;
            should_branch <= branch_next;
        end
    end

endmodule

//--- hw/cond_eval.sv
/* evaluates one of the sixteen condition codes against the incoming flags
   feeds both the jmp decision and the set result */

`timescale 1ns/1ps

module cond_eval
    import alu_pkg::*;
(
    input  cond_e  cond,
    input  flags_t flags_in,
    output logic   taken
);

    logic n_eq_v;

    // signed compare helper used by ge, l, g, le
    assign n_eq_v = (flags_in.n == flags_in.v);

    always_comb begin
        case (cond)
            cond_always: taken = 1'b1;
            cond_never:  taken = 1'b0;
            cond_eq:     taken = flags_in.z;
            cond_ne:     taken = ~flags_in.z;
            cond_cs:     taken = flags_in.c;
            cond_cc:     taken = ~flags_in.c;
            cond_os:     taken = flags_in.v;
            cond_oc:     taken = ~flags_in.v;
            cond_p:      taken = ~flags_in.n;
            cond_n:      taken = flags_in.n;
            // unsigned higher / lower or same
            cond_hi:     taken = ~flags_in.c & ~flags_in.z;
            cond_ls:     taken = flags_in.c | flags_in.z;
            cond_ge:     taken = n_eq_v;
            cond_l:      taken = ~n_eq_v;
            cond_g:      taken = ~flags_in.z & n_eq_v;
            cond_le:     taken = flags_in.z | ~n_eq_v;
            default:     taken = 1'b0;
        endcase
    end

endmodule

//--- verification/alu_properties.sv
/* concurrent checks bound into the ALU top level
   reset state, hold while disabled, z and n against the result */

`timescale 1ns/1ps

module alu_properties
    import alu_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  en,
    input logic [data_width-1:0] result,
    input flags_t                flags_out,
    input logic                  write,
    input logic                  should_branch
);

    // everything cleared one edge after reset
    reset_clears: assert property (@(posedge clk)
        rst |=> (result == '0) && (flags_out == '0) && !write && !should_branch)
        else $error("outputs not cleared after reset");

    // a disabled edge leaves the outputs alone
    hold_when_idle: assert property (@(posedge clk)
        (!rst && !en) |=> $stable(result) && $stable(flags_out)
                          && $stable(write) && $stable(should_branch))
        else $error("outputs changed on an edge with en low");

    // z and n follow the registered result
    flags_match_result: assert property (@(posedge clk)
        (!rst && en) |=> (flags_out.z == (result == '0))
                         && (flags_out.n == result[data_width-1]))
        else $error("z or n flag inconsistent with result");

endmodule

bind alu_top alu_properties props_i (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .result        (result),
    .flags_out     (flags_out),
    .write         (write),
    .should_branch (should_branch)
);

//--- verification/alu_tb.sv
/* testbench for the execute-stage ALU that drives random and swept operations
   and compares all four outputs with a reference model on every falling edge */

`timescale 1ns/1ps

module alu_tb
    import alu_pkg::*;
();

    localparam int timeout_cycles = 50;

    typedef struct packed {
        logic [data_width-1:0] result;
        flags_t                flags;
        logic                  write;
        logic                  branch;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  en;
    alu_req_t              req;
    logic [data_width-1:0] imm;
    logic [data_width-1:0] result;
    flags_t                flags_out;
    logic                  write;
    logic                  should_branch;

    expect_t expected;
    logic    model_valid = 1'b0;
    int      issued = 0;
    int      executed = 0;
    int      checks = 0;
    int      errors = 0;
    int      timeouts = 0;

    alu_op_e arith_ops[5] = '{add, sub, adc, sbb, cmp};
    alu_op_e logic_ops[7] = '{mov, and_op, or_op, xor_op, not_op, neg, test};

    alu_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .req           (req),
        .imm           (imm),
        .result        (result),
        .flags_out     (flags_out),
        .write         (write),
        .should_branch (should_branch)
    );

    always #20 clk = ~clk;

    function automatic logic cond_holds(input cond_e cond, input flags_t f);
        logic [3:0] code;
        logic       base;
        code = cond;
        case (code[3:1])
            3'd0:    base = 1'b1;
            3'd1:    base = f.z;
            3'd2:    base = f.c;
            3'd3:    base = f.v;
            3'd4:    base = ~f.n;
            3'd5:    base = ~f.c & ~f.z;
            3'd6:    base = (f.n == f.v);
            default: base = ~f.z & (f.n == f.v);
        endcase
        // each odd code is the inverse of the even code below it
        return code[0] ? ~base : base;
    endfunction

    function automatic expect_t ref_model(input alu_req_t r, input logic [15:0] imm_v);
        expect_t     e;
        logic [15:0] a;
        logic [15:0] b;
        logic [16:0] val;
        logic        taken;
        logic        arith;
        logic        sub_like;
        a        = r.rd;
        b        = r.imm_sel ? imm_v : r.rs;
        taken    = cond_holds(r.cond, r.flags_in);
        arith    = r.op inside {add, sub, adc, sbb, cmp};
        sub_like = r.op inside {sub, sbb, cmp};
        case (r.op)
            add:          val = {1'b0, a} + {1'b0, b};
            adc:          val = {1'b0, a} + {1'b0, b} + {16'd0, r.flags_in.c};
            sub, cmp:     val = {1'b0, a} - {1'b0, b};
            sbb:          val = {1'b0, a} - {1'b0, b} - {16'd0, r.flags_in.c};
            mov:          val = {1'b0, b};
            and_op, test: val = {1'b0, a & b};
            or_op:        val = {1'b0, a | b};
            xor_op:       val = {1'b0, a ^ b};
            not_op:       val = {1'b0, ~a};
            neg:          val = {1'b0, ~a + 16'd1};
            jmp:          val = r.imm_sel ? {1'b0, imm_v} : {1'b0, a};
            set:          val = {16'd0, taken};
            default:      val = '0;
        endcase
        e.result  = val[15:0];
        e.flags.c = val[16];
        e.flags.n = val[15];
        e.flags.z = (val[15:0] == 16'd0);
        e.flags.v = arith && (a[15] == (b[15] ^ sub_like)) && (val[15] != a[15]);
        e.write   = !(r.op inside {cmp, test, jmp});
        e.branch  = (r.op == jmp) && taken;
        return e;
    endfunction

    function automatic logic [15:0] pick_operand();
        case ($urandom % 8)
            0:       return 16'h0000;
            1:       return 16'h8000;
            2:       return 16'hffff;
            3:       return 16'h7fff;
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic issue(input alu_op_e op, input cond_e cond, input flags_t flags,
                         input logic en_v);
        @(negedge clk);
        req.op       = op;
        req.rd       = pick_operand();
        req.rs       = pick_operand();
        req.imm_sel  = 1'($urandom);
        req.cond     = cond;
        req.flags_in = flags;
        imm          = pick_operand();
        en           = en_v;
        if (en_v) issued++;
    endtask

    task automatic compare_field(input string name, input logic [15:0] actual,
                                 input logic [15:0] want);
        assert (actual === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, want, actual);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (executed != issued && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (executed != issued) begin
            timeouts++;
            $display("timeout: %0d issued operations never reached the outputs",
                     issued - executed);
        end
    endtask

    // model steps on the same edge as the DUT with inputs settled since the falling edge
    always @(posedge clk) begin
        if (rst) begin
            expected    <= '0;
            model_valid <= 1'b1;
        end else if (en) begin
            expected <= ref_model(req, imm);
            executed <= executed + 1;
        end
    end

    // expected only moves on enabled edges so hold edges are covered too
    always @(negedge clk) begin
        if (model_valid) begin
            checks++;
            compare_field("result", result, expected.result);
            compare_field("flags_out", 16'(flags_out), 16'(expected.flags));
            compare_field("write", 16'(write), 16'(expected.write));
            compare_field("should_branch", 16'(should_branch), 16'(expected.branch));
        end
    end

    initial begin
        void'($urandom(32'h19e210bd));
        clk = 1'b0;
        rst = 1'b1;
        en  = 1'b0;
        req = '0;
        imm = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 200; i++)
            issue(arith_ops[$urandom % 5], cond_e'(4'($urandom)), flags_t'(4'($urandom)),
                  ($urandom % 4) != 0);
        for (int i = 0; i < 200; i++)
            issue(logic_ops[$urandom % 7], cond_e'(4'($urandom)), flags_t'(4'($urandom)),
                  ($urandom % 4) != 0);
        // full condition table through set
        for (int ci = 0; ci < 16; ci++)
            for (int fi = 0; fi < 16; fi++)
                issue(set, cond_e'(4'(ci)), flags_t'(4'(fi)), 1'b1);
        for (int i = 0; i < 100; i++)
            issue(jmp, cond_e'(4'($urandom)), flags_t'(4'($urandom)), ($urandom % 4) != 0);
        // inputs keep changing while disabled
        for (int i = 0; i < 20; i++)
            issue(logic_ops[$urandom % 7], cond_e'(4'($urandom)), flags_t'(4'($urandom)), 1'b0);

        wait_drained();
        // last issued edge gets its compare on this falling edge
        @(negedge clk);
        @(posedge clk);
        $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/alu_pkg.sv
hw/cond_eval.sv
hw/alu_datapath.sv
hw/alu_writeback.sv
hw/alu_top.sv
verification/alu_properties.sv
verification/alu_tb.sv
